// File: logic/uart_rx_pkg.sv
package uart_rx_pkg;

  localparam int DATA_BITS = 8;
  localparam int WORD_BYTES = 4;
  localparam int WORD_WIDTH = DATA_BITS * WORD_BYTES;
  localparam int BIT_CNT_WIDTH = $clog2(DATA_BITS);
  localparam int BYTE_CNT_WIDTH = $clog2(WORD_BYTES);

  localparam int DIV_WIDTH = 16;
  localparam logic [DIV_WIDTH-1:0] DIV_DEFAULT = 16'd434; // 115200 baud at 50 MHz.
  localparam logic [DIV_WIDTH-1:0] DIV_MIN = 16'd4;

  localparam int CFG_ADDR_WIDTH = 1;
  localparam int CFG_DATA_WIDTH = 32;
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_DIV = 1'b0;
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_CTRL = 1'b1;

  localparam int ERR_WIDTH = 2;
  localparam int ERR_PARITY = 0;
  localparam int ERR_FRAME = 1;

  // Frame state encodings.
  localparam int RX_STATE_WIDTH = 3;
  localparam logic [RX_STATE_WIDTH-1:0] RX_IDLE = 3'd0;
  localparam logic [RX_STATE_WIDTH-1:0] RX_START = 3'd1;
  localparam logic [RX_STATE_WIDTH-1:0] RX_DATA = 3'd2;
  localparam logic [RX_STATE_WIDTH-1:0] RX_PARITY = 3'd3;
  localparam logic [RX_STATE_WIDTH-1:0] RX_STOP = 3'd4;

  // One configuration write, read by address as divisor or control bits.
  typedef union packed {
    struct packed {
      logic [CFG_DATA_WIDTH-DIV_WIDTH-1:0] unused;
      logic [DIV_WIDTH-1:0] div;
    } div_v;
    struct packed {
      logic [CFG_DATA_WIDTH-4:0] unused;
      logic parity_odd;
      logic parity_en;
      logic enable;
    } ctrl_v;
  } rx_cfg_word_u;

endpackage

// File: logic/rx_cfg_if.sv
interface rx_cfg_if import uart_rx_pkg::*; ();

  logic [DIV_WIDTH-1:0] clk_per_bit;
  logic enable;
  logic parity_en;
  logic parity_odd; // High selects odd parity.

  modport regs (
    output clk_per_bit,
    output enable,
    output parity_en,
    output parity_odd
  );

  modport rx (
    input clk_per_bit,
    input enable,
    input parity_en,
    input parity_odd
  );

endinterface

// File: logic/rx_byte_if.sv
interface rx_byte_if import uart_rx_pkg::*; ();

  logic valid; // One cycle per received frame.
  logic [DATA_BITS-1:0] data;
  logic parity_err;
  logic frame_err;

  modport src (
    output valid,
    output data,
    output parity_err,
    output frame_err
  );

  modport sink (
    input valid,
    input data,
    input parity_err,
    input frame_err
  );

endinterface

// File: logic/rx_config_regs.sv
module rx_config_regs import uart_rx_pkg::*; (
  input logic clk,
  input logic nrst,
  input logic cfg_we,
  input logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
  input rx_cfg_word_u cfg_wdata,
  rx_cfg_if.regs cfg
);

  logic [DIV_WIDTH-1:0] div_q;
  logic enable_q;
  logic parity_en_q;
  logic parity_odd_q;
  logic [DIV_WIDTH-1:0] div_clamped;

  // Too small a divisor leaves no room for the half-bit check.
  assign div_clamped = (cfg_wdata.div_v.div < DIV_MIN) ? DIV_MIN : cfg_wdata.div_v.div;

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      div_q <= DIV_DEFAULT;
      enable_q <= 1'b0;
      parity_en_q <= 1'b0;
      parity_odd_q <= 1'b0;
    end
    else if (cfg_we)
    begin
      case (cfg_addr)
        ADDR_DIV:
        begin
          div_q <= div_clamped;
        end
        ADDR_CTRL:
        begin
          enable_q <= cfg_wdata.ctrl_v.enable;
          parity_en_q <= cfg_wdata.ctrl_v.parity_en;
          parity_odd_q <= cfg_wdata.ctrl_v.parity_odd;
        end
      endcase
    end
  end

  assign cfg.clk_per_bit = div_q;
  assign cfg.enable = enable_q;
  assign cfg.parity_en = parity_en_q;
  assign cfg.parity_odd = parity_odd_q;

endmodule

// File: logic/uart_byte_rx.sv
module uart_byte_rx import uart_rx_pkg::*; (
  input logic clk,
  input logic nrst,
  input logic rx,
  rx_cfg_if.rx cfg,
  rx_byte_if.src byte_out
);

  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic start_edge;

  logic [RX_STATE_WIDTH-1:0] state;
  logic [DIV_WIDTH-1:0] cnt;
  logic [BIT_CNT_WIDTH-1:0] bit_cnt;
  logic valid_q;

  logic [DIV_WIDTH-1:0] div_q;
  logic par_en_q;
  logic par_odd_q;
  logic [DATA_BITS-1:0] shreg;
  logic parity_err_q;
  logic frame_err_q;

  logic half_done;
  logic bit_done;
  logic calc_parity;

  // Two-flop synchronizer plus one stage for edge detection.
  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // A falling edge needs the line high first, so a low stop bit
  // holds off the next frame until the line recovers.
  assign start_edge = rx_prev & ~rx_sync;

  assign half_done = (cnt == {1'b0, div_q[DIV_WIDTH-1:1]});
  assign bit_done = (cnt == div_q);
  assign calc_parity = (^shreg) ^ par_odd_q; // Expected parity bit.

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      state <= RX_IDLE;
      cnt <= '0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      cnt <= cnt + 1'b1;
      if (!cfg.enable)
      begin
        state <= RX_IDLE;
      end
      else
      begin
        case (state)
          RX_IDLE:
          begin
            if (start_edge)
            begin
              cnt <= DIV_WIDTH'(1);
              state <= RX_START;
            end
          end
          RX_START:
          begin
            if (half_done)
            begin
              cnt <= DIV_WIDTH'(1);
              bit_cnt <= '0;
              state <= rx_sync ? RX_IDLE : RX_DATA; // High here is a glitch.
            end
          end
          RX_DATA:
          begin
            if (bit_done)
            begin
              cnt <= DIV_WIDTH'(1);
              if (bit_cnt == BIT_CNT_WIDTH'(DATA_BITS - 1))
              begin
                state <= par_en_q ? RX_PARITY : RX_STOP;
              end
              else
              begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end
          RX_PARITY:
          begin
            if (bit_done)
            begin
              cnt <= DIV_WIDTH'(1);
              state <= RX_STOP;
            end
          end
          RX_STOP:
          begin
            if (bit_done)
            begin
              valid_q <= 1'b1;
              state <= RX_IDLE;
            end
          end
          default:
          begin
            state <= RX_IDLE;
          end
        endcase
      end
    end
  end

  // Frame payload, captured at the sample points.
  always_ff @(posedge clk)
  begin
    if (state == RX_IDLE && start_edge)
    begin
      div_q <= cfg.clk_per_bit; // Held for the whole frame.
      par_en_q <= cfg.parity_en;
      par_odd_q <= cfg.parity_odd;
      parity_err_q <= 1'b0;
    end
    if (state == RX_DATA && bit_done)
    begin
      shreg <= {rx_sync, shreg[DATA_BITS-1:1]}; // LSB first.
    end
    if (state == RX_PARITY && bit_done)
    begin
      parity_err_q <= rx_sync ^ calc_parity;
    end
    if (state == RX_STOP && bit_done)
    begin
      frame_err_q <= ~rx_sync;
    end
  end

  assign byte_out.valid = valid_q;
  assign byte_out.data = shreg;
  assign byte_out.parity_err = parity_err_q;
  assign byte_out.frame_err = frame_err_q;

endmodule

// File: logic/word_assembler.sv
module word_assembler import uart_rx_pkg::*; (
  input logic clk,
  input logic nrst,
  input logic enable,
  rx_byte_if.sink byte_in,
  output logic done,
  output logic [WORD_WIDTH-1:0] data_out,
  output logic [ERR_WIDTH-1:0] word_err
);

  logic [BYTE_CNT_WIDTH-1:0] byte_cnt;
  logic last_byte;
  logic [WORD_WIDTH-1:0] stage;
  logic [WORD_WIDTH-1:0] stage_next;
  logic [ERR_WIDTH-1:0] err_stage;
  logic [ERR_WIDTH-1:0] err_byte;
  logic [ERR_WIDTH-1:0] err_next;

  assign last_byte = (byte_cnt == BYTE_CNT_WIDTH'(WORD_BYTES - 1));

  always_comb
  begin
    err_byte = '0;
    err_byte[ERR_PARITY] = byte_in.parity_err;
    err_byte[ERR_FRAME] = byte_in.frame_err;
    // First byte of a word starts a fresh error field.
    err_next = ((byte_cnt == '0) ? '0 : err_stage) | err_byte;
    stage_next = stage;
    stage_next[byte_cnt*DATA_BITS +: DATA_BITS] = byte_in.data;
  end

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      byte_cnt <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (!enable)
      begin
        byte_cnt <= '0;
      end
      else if (byte_in.valid)
      begin
        if (last_byte)
        begin
          byte_cnt <= '0;
          done <= 1'b1;
        end
        else
        begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (byte_in.valid)
    begin
      stage <= stage_next;
      err_stage <= err_next;
      if (last_byte)
      begin
        data_out <= stage_next; // Held until the next word.
        word_err <= err_next;
      end
    end
  end

endmodule

// File: logic/uart_word_rx.sv
module uart_word_rx import uart_rx_pkg::*; (
  input logic clk,
  input logic nrst,
  input logic rx,
  input logic cfg_we,
  input logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
  input logic [CFG_DATA_WIDTH-1:0] cfg_wdata,
  output logic done,
  output logic [WORD_WIDTH-1:0] data_out,
  output logic [ERR_WIDTH-1:0] word_err
);

  rx_cfg_if cfg_if ();
  rx_byte_if byte_if ();

  rx_config_regs rx_config_regs_i (
    .clk (clk),
    .nrst (nrst),
    .cfg_we (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg (cfg_if.regs)
  );

  uart_byte_rx uart_byte_rx_i (
    .clk (clk),
    .nrst (nrst),
    .rx (rx),
    .cfg (cfg_if.rx),
    .byte_out (byte_if.src)
  );

  // Disabling the receiver also drops a partly collected word.
  word_assembler word_assembler_i (
    .clk (clk),
    .nrst (nrst),
    .enable (cfg_if.enable),
    .byte_in (byte_if.sink),
    .done (done),
    .data_out (data_out),
    .word_err (word_err)
  );

endmodule

// File: verification/uart_word_rx_properties.sv
module uart_word_rx_properties import uart_rx_pkg::*; (
  input logic clk,
  input logic nrst,
  input logic done,
  input logic byte_valid,
  input logic [DIV_WIDTH-1:0] clk_per_bit
);

  int failures = 0;

  done_single: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
    else
    begin
      $error("done was high for two cycles in a row");
      failures++;
    end

  valid_single: assert property (@(posedge clk) disable iff (!nrst) byte_valid |=> !byte_valid)
    else
    begin
      $error("byte valid was high for two cycles in a row");
      failures++;
    end

  // One reset edge is needed before the flops are known.
  reset_quiet: assert property (@(posedge clk)
    (!nrst && $past(!nrst)) |-> (!done && !byte_valid))
    else
    begin
      $error("done or byte valid was high during reset");
      failures++;
    end

  div_floor: assert property (@(posedge clk) disable iff (!nrst) clk_per_bit >= DIV_MIN)
    else
    begin
      $error("bit divisor fell below the minimum");
      failures++;
    end

endmodule

bind uart_word_rx uart_word_rx_properties uart_word_rx_properties_i (
  .clk (clk),
  .nrst (nrst),
  .done (done),
  .byte_valid (byte_if.valid),
  .clk_per_bit (cfg_if.clk_per_bit)
);

// File: verification/uart_word_rx_tb.sv
module uart_word_rx_tb import uart_rx_pkg::*; ();

  typedef struct packed {
    logic [DIV_WIDTH-1:0] div;
    logic par_en;
    logic par_odd;
    logic [0:WORD_BYTES-1][DATA_BITS-1:0] tx_bytes; // Index 0 is sent first.
    logic [WORD_BYTES-1:0] bad_par;
    logic [WORD_BYTES-1:0] bad_stop;
    logic glitch;
    logic [WORD_WIDTH-1:0] exp_word;
    logic [ERR_WIDTH-1:0] exp_err;
  } test_row_t;

  logic clk;
  logic nrst;
  logic rx;
  logic cfg_we;
  logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
  logic [CFG_DATA_WIDTH-1:0] cfg_wdata;
  logic done;
  logic [WORD_WIDTH-1:0] data_out;
  logic [ERR_WIDTH-1:0] word_err;

  test_row_t rows[$];
  string names[$];
  int done_count = 0;
  int cycle_count = 0;
  int timeout_limit = 0;
  int pass_count = 0;
  int fail_count = 0;

  uart_word_rx uart_word_rx_i (
    .clk (clk),
    .nrst (nrst),
    .rx (rx),
    .cfg_we (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .done (done),
    .data_out (data_out),
    .word_err (word_err)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    if (nrst && done)
    begin
      done_count <= done_count + 1;
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit)
    begin
      $display("Timeout after %0d cycles: done never arrived", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic void add_row(input string name, input logic [DIV_WIDTH-1:0] div,
      input logic par_en, input logic par_odd,
      input logic [0:WORD_BYTES-1][DATA_BITS-1:0] tx_bytes,
      input logic [WORD_BYTES-1:0] bad_par, input logic [WORD_BYTES-1:0] bad_stop,
      input logic glitch, input logic [WORD_WIDTH-1:0] exp_word,
      input logic [ERR_WIDTH-1:0] exp_err);
    test_row_t r;
    r.div = div;
    r.par_en = par_en;
    r.par_odd = par_odd;
    r.tx_bytes = tx_bytes;
    r.bad_par = bad_par;
    r.bad_stop = bad_stop;
    r.glitch = glitch;
    r.exp_word = exp_word;
    r.exp_err = exp_err;
    rows.push_back(r);
    names.push_back(name);
  endfunction

  // Five frames of eleven bits per word bounds each row.
  function automatic int timeout_cycles();
    int total;
    total = 500; // Reset and register writes.
    foreach (rows[i])
    begin
      total += 5 * 11 * int'(rows[i].div);
    end
    return total;
  endfunction

  task automatic hold_line(input logic level, input int cycles);
    rx = level;
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  task automatic send_frame(input logic [DATA_BITS-1:0] data, input int div,
      input logic par_en, input logic par_odd, input logic bad_par, input logic bad_stop);
    logic par_bit;
    par_bit = (^data) ^ par_odd ^ bad_par;
    hold_line(1'b0, div);
    for (int i = 0; i < DATA_BITS; i++)
    begin
      hold_line(data[i], div);
    end
    if (par_en)
    begin
      hold_line(par_bit, div);
    end
    hold_line(~bad_stop, div);
    hold_line(1'b1, div); // Idle gap, the line must be seen high again.
  endtask

  task automatic write_cfg(input logic [CFG_ADDR_WIDTH-1:0] addr, input rx_cfg_word_u word);
    cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_wdata = word;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic run_test(input int idx);
    test_row_t r;
    rx_cfg_word_u w;
    int target;
    logic ok;
    r = rows[idx];
    ok = 1'b1;
    w = '0;
    w.div_v.div = r.div;
    write_cfg(ADDR_DIV, w);
    w = '0;
    w.ctrl_v.enable = 1'b1;
    w.ctrl_v.parity_en = r.par_en;
    w.ctrl_v.parity_odd = r.par_odd;
    write_cfg(ADDR_CTRL, w);
    target = done_count + 1;
    if (r.glitch)
    begin
      hold_line(1'b0, int'(r.div) / 4); // Well under half a bit.
      hold_line(1'b1, int'(r.div));
    end
    for (int b = 0; b < WORD_BYTES; b++)
    begin
      send_frame(r.tx_bytes[b], int'(r.div), r.par_en, r.par_odd, r.bad_par[b], r.bad_stop[b]);
    end
    while (done_count < target)
    begin
      @(posedge clk);
      #1;
    end
    assert (done_count == target)
    else
    begin
      $display("Test %s saw more than one done pulse", names[idx]);
      ok = 1'b0;
    end
    assert (data_out == r.exp_word)
    else
    begin
      $display("Mismatch in %s: data_out expected %h, actual %h",
        names[idx], r.exp_word, data_out);
      ok = 1'b0;
    end
    assert (word_err == r.exp_err)
    else
    begin
      $display("Mismatch in %s: word_err expected %b, actual %b",
        names[idx], r.exp_err, word_err);
      ok = 1'b0;
    end
    if (ok)
    begin
      pass_count++;
      $display("Test %s: pass", names[idx]);
    end
    else
    begin
      fail_count++;
      $display("Test %s: fail", names[idx]);
    end
  endtask

  initial
  begin
    rx_cfg_word_u w;
    int prop_failures;
    clk = 1'b0;
    nrst = 1'b0;
    rx = 1'b1;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    // Error field literals follow ERR_PARITY in bit 0 and ERR_FRAME in bit 1.
    add_row("plain", 16'd8, 1'b0, 1'b0, {8'h11, 8'h22, 8'h33, 8'h44},
      4'b0000, 4'b0000, 1'b0, 32'h4433_2211, 2'b00);
    add_row("even_parity", 16'd10, 1'b1, 1'b0, {8'ha5, 8'h3c, 8'h0f, 8'hf0},
      4'b0000, 4'b0000, 1'b0, 32'hf00f_3ca5, 2'b00);
    add_row("odd_parity", 16'd12, 1'b1, 1'b1, {8'h01, 8'h80, 8'h7e, 8'h55},
      4'b0000, 4'b0000, 1'b0, 32'h557e_8001, 2'b00);
    add_row("bad_parity", 16'd8, 1'b1, 1'b0, {8'hde, 8'had, 8'hbe, 8'hef},
      4'b0100, 4'b0000, 1'b0, 32'hefbe_adde, 2'b01);
    add_row("frame_error", 16'd9, 1'b0, 1'b0, {8'h12, 8'h34, 8'h56, 8'h78},
      4'b0000, 4'b0010, 1'b0, 32'h7856_3412, 2'b10);
    add_row("glitch_start", 16'd16, 1'b0, 1'b0, {8'hca, 8'hfe, 8'hba, 8'hbe},
      4'b0000, 4'b0000, 1'b1, 32'hbeba_feca, 2'b00);
    add_row("div_8", 16'd8, 1'b0, 1'b0, {8'h5a, 8'hc3, 8'h99, 8'h66},
      4'b0000, 4'b0000, 1'b0, 32'h6699_c35a, 2'b00);
    add_row("div_13", 16'd13, 1'b0, 1'b0, {8'h0d, 8'h0e, 8'h0a, 8'h0d},
      4'b0000, 4'b0000, 1'b0, 32'h0d0a_0e0d, 2'b00);
    timeout_limit = timeout_cycles();
    repeat (10) @(posedge clk);
    #1;
    nrst = 1'b1;
    @(posedge clk);
    #1;
    w = '0;
    w.div_v.div = 16'd1; // Below DIV_MIN, so the register clamps it.
    write_cfg(ADDR_DIV, w);
    foreach (rows[i])
    begin
      run_test(i);
    end
    prop_failures = uart_word_rx_i.uart_word_rx_properties_i.failures;
    $display("Tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
      rows.size(), pass_count, fail_count, prop_failures);
    if (fail_count == 0 && prop_failures == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: build.f
logic/uart_rx_pkg.sv
logic/rx_cfg_if.sv
logic/rx_byte_if.sv
logic/rx_config_regs.sv
logic/uart_byte_rx.sv
logic/word_assembler.sv
logic/uart_word_rx.sv
verification/uart_word_rx_properties.sv
verification/uart_word_rx_tb.sv

// File: Makefile
# Verilator build and run of the serial word receiver testbench.

VERILATOR ?= verilator
TOP ?= uart_word_rx_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so a crash also counts as a failure.
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
